//--- all.f
+incdir+.
ps2_pkg.sv
ps2_rx_frame.sv
ps2_byte_fifo.sv
ps2_port_merge.sv
ps2_dual_rx.sv
tb_ps2_dual_rx.sv

//--- Bender.yml
package:
  name: ps2_dual_rx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ps2_pkg.sv
      - ps2_rx_frame.sv
      - ps2_byte_fifo.sv
      - ps2_port_merge.sv
      - ps2_dual_rx.sv
  - target: test
    files:
      - tb_ps2_dual_rx.sv

//--- tb_ps2_dual_rx.sv
`timescale 1ns/1ps
`include "ps2_consts.svh"

module tb_ps2_dual_rx
	import ps2_pkg::*;
;

	// One PS/2 bit is 20 clk cycles, plus a short gap after the frame
	localparam int FRAME_CYCLES = 11 * 20 + 15;
	// Frame slots in the whole run, concurrent frames counted once
	localparam int FRAME_SLOTS  = 20;
	localparam int QUIET_CYCLES = `PS2_TIMEOUT_CYCLES + 50;
	localparam int RUN_CYCLES   = FRAME_SLOTS * FRAME_CYCLES + QUIET_CYCLES + 3 * 8;
	localparam int WATCHDOG_CYCLES = (RUN_CYCLES * 3) / 2 + 3000;

	logic       clk;
	logic       rst;
	logic       rx_en;
	logic [1:0] ps2_clk_line;
	logic [1:0] ps2_data_line;
	logic       out_pop;
	logic       out_avail;
	logic       out_port;
	ps2_byte_t  out_byte;
	logic       overflow0;
	logic       overflow1;

	// Expected entries per port and reader controls
	ps2_byte_t exp_q0[$];
	ps2_byte_t exp_q1[$];
	logic      port_log[$];
	logic      hold;
	logic      log_ports;
	int        mismatches;
	int        other_errs;
	int        seed_val;

	ps2_dual_rx u_dut (
		.clk       (clk),
		.rst       (rst),
		.rx_en     (rx_en),
		.ps2_clk0  (ps2_clk_line[0]),
		.ps2_data0 (ps2_data_line[0]),
		.ps2_clk1  (ps2_clk_line[1]),
		.ps2_data1 (ps2_data_line[1]),
		.out_pop   (out_pop),
		.out_avail (out_avail),
		.out_port  (out_port),
		.out_byte  (out_byte),
		.overflow0 (overflow0),
		.overflow1 (overflow1)
	);

	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// PS/2 device model
	//////////////////////////////////////////////////

	// Start, 8 data LSB first, odd parity, stop
	task automatic send_frame(input int port, input logic [7:0] data, input logic bad_par,
	                          input logic stop_low, input int nbits);
		logic [10:0] bits;
		ps2_byte_t   exp;
		int          qsize;
		bits  = {~stop_low, (~^data) ^ bad_par, data, 1'b0};
		qsize = (port == 0) ? exp_q0.size() : exp_q1.size();
		// Only whole frames with the receiver enabled land in the FIFO
		// A held reader lets the FIFO fill, later bytes are dropped
		if (nbits == 11 && rx_en && !(hold && qsize >= `PS2_FIFO_DEPTH))
		begin
			// Inverted parity and a low stop bit each flag their own error
			exp.data       = data;
			exp.err.parity = bad_par;
			exp.err.stop   = stop_low;
			if (port == 0)
				exp_q0.push_back(exp);
			else
				exp_q1.push_back(exp);
		end
		for (int i = 0; i < nbits; i++)
		begin
			// Data changes in the middle of the high phase
			repeat (5) @(negedge clk);
			ps2_data_line[port] = bits[i];
			repeat (5) @(negedge clk);
			ps2_clk_line[port] = 1'b0;
			repeat (10) @(negedge clk);
			ps2_clk_line[port] = 1'b1;
		end
		// Bus released back to idle
		repeat (5) @(negedge clk);
		ps2_data_line[port] = 1'b1;
		repeat (10) @(negedge clk);
	endtask

	task automatic send_random(input int port, input int count);
		for (int i = 0; i < count; i++)
			send_frame(port, 8'($urandom()), 1'b0, 1'b0, 11);
	endtask

	//////////////////////////////////////////////////
	// Scoreboard and reader
	//////////////////////////////////////////////////

	task automatic check_pop();
		ps2_byte_t exp;
		int        qsize;
		qsize = out_port ? exp_q1.size() : exp_q0.size();
		if (log_ports)
			port_log.push_back(out_port);
		assert (qsize != 0)
		else
		begin
			$display("%0t: byte received with empty expectation queue on port %0d",
			         $time, out_port);
			other_errs++;
		end
		if (qsize != 0)
		begin
			if (out_port)
				exp = exp_q1.pop_front();
			else
				exp = exp_q0.pop_front();
			assert (out_byte === exp)
			else
			begin
				$display("MISMATCH time=%0t signal=out_byte port=%0d expected=%h actual=%h",
				         $time, out_port, exp, out_byte);
				mismatches++;
			end
		end
	endtask

	// Pop decided and checked on the falling edge, taken at the next rising edge
	always @(negedge clk)
	begin
		if (rst || hold || !out_avail)
			out_pop = 1'b0;
		else
		begin
			out_pop = 1'b1;
			check_pop();
		end
	end

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < max_cycles)
		begin
			@(negedge clk);
			n++;
		end
		assert (exp_q0.size() == 0 && exp_q1.size() == 0)
		else
		begin
			$display("%0t: expected bytes never arrived (%0d on port 0, %0d on port 1)",
			         $time, exp_q0.size(), exp_q1.size());
			other_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
			         $time, name, expected, actual);
			mismatches++;
		end
	endtask

	// Reset and the idle state right after it
	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_bit("out_avail", out_avail, 1'b0);
		check_bit("overflow0", overflow0, 1'b0);
		check_bit("overflow1", overflow1, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		clk           = 1'b0;
		rst           = 1'b1;
		rx_en         = 1'b1;
		ps2_clk_line  = 2'b11;
		ps2_data_line = 2'b11;
		out_pop       = 1'b0;
		hold          = 1'b0;
		log_ports     = 1'b0;
		mismatches    = 0;
		other_errs    = 0;
		seed_val      = $urandom(2);

		apply_reset();

		// Clean frame on each port
		send_random(0, 1);
		send_random(1, 1);
		wait_drain(200);

		// Parity error, stop error, then both
		send_frame(0, 8'h5a, 1'b1, 1'b0, 11);
		send_frame(1, 8'h3c, 1'b0, 1'b1, 11);
		send_frame(0, 8'hff, 1'b1, 1'b1, 11);
		wait_drain(200);

		// Start plus 5 data bits, then quiet past the timeout
		send_frame(0, 8'ha5, 1'b0, 1'b0, 6);
		repeat (QUIET_CYCLES) @(negedge clk);
		send_random(0, 1);
		wait_drain(200);
		// Receiver disabled for a whole frame
		rx_en = 1'b0;
		send_frame(1, 8'h81, 1'b0, 1'b0, 11);
		rx_en = 1'b1;
		wait_drain(200);

		// Tie order depends on the last-served register
		apply_reset();

		// Both ports at once behind a blocked reader
		hold = 1'b1;
		fork
			send_random(0, 3);
			send_random(1, 3);
		join
		repeat (10) @(negedge clk);
		log_ports = 1'b1;
		hold      = 1'b0;
		wait_drain(200);
		log_ports = 1'b0;
		assert (port_log.size() == 6)
		else
		begin
			$display("%0t: wrong number of pops in the two-port burst (%0d)",
			         $time, port_log.size());
			other_errs++;
		end
		for (int i = 0; i < port_log.size(); i++)
			check_bit("out_port", port_log[i], 1'(i % 2));

		// Port 0 overflow with the reader blocked
		hold = 1'b1;
		send_random(0, `PS2_FIFO_DEPTH + 2);
		repeat (10) @(negedge clk);
		check_bit("overflow0", overflow0, 1'b1);
		check_bit("overflow1", overflow1, 1'b0);
		hold = 1'b0;
		wait_drain(200);
		// Dropped bytes must not show up late
		repeat (50) @(negedge clk);
		check_bit("out_avail", out_avail, 1'b0);

		$display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
		if (mismatches == 0 && other_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- ps2_dual_rx.sv
`timescale 1ns/1ps

module ps2_dual_rx
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      rx_en,
	input  logic      ps2_clk0,
	input  logic      ps2_data0,
	input  logic      ps2_clk1,
	input  logic      ps2_data1,
	input  logic      out_pop,
	output logic      out_avail,
	output logic      out_port,
	output ps2_byte_t out_byte,
	output logic      overflow0,
	output logic      overflow1
);

	logic      byte_valid0;
	logic      byte_valid1;
	ps2_byte_t byte_data0;
	ps2_byte_t byte_data1;
	logic      empty0;
	logic      empty1;
	ps2_byte_t head0;
	ps2_byte_t head1;
	logic      pop0;
	logic      pop1;

	//////////////////////////////////////////////////
	// Port 0 receive path
	//////////////////////////////////////////////////

	ps2_rx_frame u_rx0 (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.ps2_clk    (ps2_clk0),
		.ps2_data   (ps2_data0),
		.byte_valid (byte_valid0),
		.byte_data  (byte_data0)
	);

	ps2_byte_fifo u_fifo0 (
		.clk      (clk),
		.rst      (rst),
		.wr       (byte_valid0),
		.wr_data  (byte_data0),
		.rd       (pop0),
		.rd_data  (head0),
		.empty    (empty0),
		.overflow (overflow0)
	);

	//////////////////////////////////////////////////
	// Port 1 receive path
	//////////////////////////////////////////////////

	ps2_rx_frame u_rx1 (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.ps2_clk    (ps2_clk1),
		.ps2_data   (ps2_data1),
		.byte_valid (byte_valid1),
		.byte_data  (byte_data1)
	);

	ps2_byte_fifo u_fifo1 (
		.clk      (clk),
		.rst      (rst),
		.wr       (byte_valid1),
		.wr_data  (byte_data1),
		.rd       (pop1),
		.rd_data  (head1),
		.empty    (empty1),
		.overflow (overflow1)
	);

	//////////////////////////////////////////////////
	// Tagged output stream
	//////////////////////////////////////////////////

	ps2_port_merge u_merge (
		.clk       (clk),
		.rst       (rst),
		.empty0    (empty0),
		.empty1    (empty1),
		.head0     (head0),
		.head1     (head1),
		.out_pop   (out_pop),
		.pop0      (pop0),
		.pop1      (pop1),
		.out_avail (out_avail),
		.out_port  (out_port),
		.out_byte  (out_byte)
	);

endmodule

//--- ps2_port_merge.sv
`timescale 1ns/1ps

module ps2_port_merge
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      empty0,
	input  logic      empty1,
	input  ps2_byte_t head0,
	input  ps2_byte_t head1,
	input  logic      out_pop,
	output logic      pop0,
	output logic      pop1,
	output logic      out_avail,
	output logic      out_port,
	output ps2_byte_t out_byte
);

	// Port that took the most recent pop
	logic last_q;
	// Port currently presented
	logic sel;
	logic accept;

	//////////////////////////////////////////////////
	// Round-robin selection
	//////////////////////////////////////////////////

	always_comb
	begin
		if (empty0)
			sel = 1'b1;
		else if (empty1)
			sel = 1'b0;
		else
			// Both waiting so the other port gets its turn
			sel = ~last_q;
	end

	assign out_avail = ~empty0 | ~empty1;
	assign out_port  = sel;
	assign out_byte  = sel ? head1 : head0;

	//////////////////////////////////////////////////
	// Pop routing
	//////////////////////////////////////////////////

	// Pop with nothing presented is ignored
	assign accept = out_pop & out_avail;
	assign pop0   = accept & ~sel;
	assign pop1   = accept & sel;

	always_ff @(posedge clk)
	begin
		if (rst)
			// Points at port 1 so port 0 takes the first tie
			last_q <= 1'b1;
		else if (accept)
			last_q <= sel;
	end

endmodule

//--- ps2_byte_fifo.sv
`timescale 1ns/1ps
`include "ps2_consts.svh"

module ps2_byte_fifo
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      wr,
	input  ps2_byte_t wr_data,
	input  logic      rd,
	output ps2_byte_t rd_data,
	output logic      empty,
	output logic      overflow
);

	localparam int AW = $clog2(`PS2_FIFO_DEPTH);

	ps2_byte_t mem [`PS2_FIFO_DEPTH];

	// Extra MSB tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        do_wr;
	logic        do_rd;

	//////////////////////////////////////////////////
	// Status and accept logic
	//////////////////////////////////////////////////

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_rd = rd && !empty;
	// Pop in the same cycle frees the slot being written
	assign do_wr = wr && (!full || do_rd);

	// Head shown straight from the array
	assign rd_data = mem[rd_ptr[AW-1:0]];

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Sticky until reset
			if (wr && !do_wr)
				overflow <= 1'b1;
		end
	end

endmodule

//--- ps2_rx_frame.sv
`timescale 1ns/1ps
`include "ps2_consts.svh"

module ps2_rx_frame
	import ps2_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      rx_en,
	input  logic      ps2_clk,
	input  logic      ps2_data,
	output logic      byte_valid,
	output ps2_byte_t byte_data
);

	// Wide enough to hold the full timeout count
	localparam int TO_W = $clog2(`PS2_TIMEOUT_CYCLES + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY,
		ST_STOP,
		ST_DONE
	} rx_state_t;

	rx_state_t state;
	rx_state_t state_nxt;

	logic [`PS2_SYNC_STAGES-1:0] clk_sync;
	logic [`PS2_SYNC_STAGES-1:0] data_sync;
	logic                        clk_s;
	logic                        data_s;
	logic                        clk_prev;
	logic                        fall;

	logic [2:0]      bit_cnt;
	logic [7:0]      shift_q;
	ps2_err_t        err_q;
	logic [TO_W-1:0] to_cnt;
	logic            timed_out;

	//////////////////////////////////////////////////
	// Line synchronizers and edge detect
	//////////////////////////////////////////////////

	// Both lines idle high on the bus
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end
		else
		begin
			clk_sync  <= {clk_sync[`PS2_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_s;
		end
	end

	assign clk_s  = clk_sync[`PS2_SYNC_STAGES-1];
	assign data_s = data_sync[`PS2_SYNC_STAGES-1];

	// Device drives data while the clock is high
	// so data is stable when the clock falls
	assign fall = clk_prev & ~clk_s;

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	assign timed_out = (to_cnt == TO_W'(`PS2_TIMEOUT_CYCLES));

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
			begin
				// Start bit is a falling edge with data low
				if (rx_en && fall && !data_s)
					state_nxt = ST_DATA;
			end
			ST_DATA:
			begin
				if (timed_out)
					state_nxt = ST_IDLE;
				else if (fall && bit_cnt == 3'd7)
					state_nxt = ST_PARITY;
			end
			ST_PARITY:
			begin
				if (timed_out)
					state_nxt = ST_IDLE;
				else if (fall)
					state_nxt = ST_STOP;
			end
			ST_STOP:
			begin
				if (timed_out)
					state_nxt = ST_IDLE;
				else if (fall)
					state_nxt = ST_DONE;
			end
			// Single cycle to hand the byte out
			ST_DONE:
				state_nxt = ST_IDLE;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state      <= ST_IDLE;
			to_cnt     <= '0;
			byte_valid <= 1'b0;
		end
		else
		begin
			state      <= state_nxt;
			byte_valid <= (state == ST_DONE);
			// Restart on every edge, hold at zero outside a frame
			if (state == ST_IDLE || state == ST_DONE || fall)
				to_cnt <= '0;
			else
				to_cnt <= to_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Shift register and error bits
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// Fresh counter and error bits for the next frame
		if (state == ST_IDLE)
		begin
			bit_cnt <= '0;
			err_q   <= '0;
		end
		// LSB arrives first so shift toward bit 0
		if (state == ST_DATA && fall)
		begin
			shift_q <= {data_s, shift_q[7:1]};
			bit_cnt <= bit_cnt + 1'b1;
		end
		// Odd parity expects the inverted XOR of the data
		if (state == ST_PARITY && fall)
			err_q.parity <= (data_s != ~^shift_q);
		if (state == ST_STOP && fall)
			err_q.stop <= ~data_s;
		// Payload held until the next frame completes
		if (state == ST_DONE)
		begin
			byte_data.data <= shift_q;
			byte_data.err  <= err_q;
		end
	end

endmodule

//--- ps2_pkg.sv
package ps2_pkg;

	//////////////////////////////////////////////////
	// Error code of one received frame
	//////////////////////////////////////////////////

	// Bit 1 stop error, bit 0 parity error
	typedef struct packed {
		// Stop bit sampled low
		logic stop;
		// Parity bit did not give odd parity
		logic parity;
	} ps2_err_t;

	//////////////////////////////////////////////////
	// One received byte with its status
	//////////////////////////////////////////////////

	// Data in the upper eight bits, error code below
	// 10 bits in total
	typedef struct packed {
		logic [7:0] data;
		ps2_err_t   err;
	} ps2_byte_t;

endpackage

//--- ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

//////////////////////////////////////////////////
// Port FIFO sizing
//////////////////////////////////////////////////

// Entries per port FIFO
// Must stay a power of two for the pointer wrap
`define PS2_FIFO_DEPTH 8

//////////////////////////////////////////////////
// Receiver timing
//////////////////////////////////////////////////

// Idle clk cycles between PS/2 falling edges before a frame is dropped
// Short value suits simulation
// A real 100 MHz system wants something near 100 us worth of cycles
`define PS2_TIMEOUT_CYCLES 200

// Flops in each PS/2 line synchronizer
`define PS2_SYNC_STAGES 2

`endif
